// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= coreBench
BUILD_DIR ?= obj_dir
FILELIST ?= verilog.f
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= All tests passed!

SOURCES := $(wildcard hdl/*.sv) $(wildcard bench/*.sv)
BIN := $(BUILD_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/coreBench.sv ====
`timescale 1ns/10ps

module coreBench;

	logic clk;
	logic arstN;
	corePkg::word_t pcFetch;
	corePkg::word_t fetchInstr;
	corePkg::word_t dmAddr;
	corePkg::word_t dmWData;
	corePkg::byteEn_t dmByteEn;
	logic dmWe;
	corePkg::word_t dmRData;
	logic wbWe;
	corePkg::regAddr_t wbReg;
	corePkg::word_t wbData;

	corePkg::word_t imem [0:255];
	corePkg::word_t dmem [0:1023];
	corePkg::word_t fetchIdx;
	int numWords = 0;

	// Expected streams with one entry per record
	int wGrp[$];
	logic [31:0] wReg[$];
	logic [31:0] wVal[$];
	int sGrp[$];
	logic [31:0] sAddr[$];
	logic [31:0] sData[$];
	logic [31:0] sBe[$];

	int errorCount = 0;
	int checkCount = 0;
	int groupErr [0:3];
	int curGroup = 0;
	int cycles = 0;
	int limit;
	bit monitorOn = 0;

	coreTop UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Instruction and data memory models
	assign fetchIdx = (pcFetch - corePkg::ResetPc) >> 2;
	assign fetchInstr = (fetchIdx < numWords) ? imem[fetchIdx[7:0]] : '0;
	assign dmRData = dmem[dmAddr[11:2]];

	always @(posedge clk) begin
		if (dmWe) begin
			for (int b = 0; b < 4; b++)
				if (dmByteEn[b])
					dmem[dmAddr[11:2]][8*b +: 8] <= dmWData[8*b +: 8];
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errorCount++;
			groupErr[curGroup]++;
		end
	endtask

	function automatic bit groupPending(int g);
		foreach (wGrp[i])
			if (wGrp[i] == g)
				return 1'b1;
		foreach (sGrp[i])
			if (sGrp[i] == g)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic string groupName(int g);
		case (g)
			0: return "reset";
			1: return "alu and forwarding";
			2: return "loads and stores";
			default: return "branches and jumps";
		endcase
	endfunction

	task automatic reportGroup(input int g);
		if (!groupPending(g))
			$display("Group %0d (%s) done, %0d errors", g, groupName(g), groupErr[g]);
	endtask

	task automatic readProgram();
		int fd;
		int code;
		int g;
		string tag;
		string line;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		fd = $fopen("bench/programInput.txt", "r");
		if (fd == 0) begin
			$display("Cannot open bench/programInput.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1)
				break;
			if (tag == "#") begin
				code = $fgets(line, fd);
			end else if (tag == "I") begin
				code = $fscanf(fd, "%h", d);
				imem[numWords] = d;
				numWords++;
			end else if (tag == "D") begin
				code = $fscanf(fd, "%h %h", a, d);
				dmem[a[11:2]] <= d;
			end else if (tag == "W") begin
				code = $fscanf(fd, "%d %d %h", g, a, d);
				wGrp.push_back(g);
				wReg.push_back(a);
				wVal.push_back(d);
			end else if (tag == "S") begin
				code = $fscanf(fd, "%d %h %h %h", g, a, d, e);
				sGrp.push_back(g);
				sAddr.push_back(a);
				sData.push_back(d);
				sBe.push_back(e);
			end else begin
				$display("Unknown record tag %s in data file", tag);
				errorCount++;
			end
		end
		$fclose(fd);
	endtask

	// Stream monitor samples at the falling edge where outputs are settled
	always @(negedge clk) begin
		if (monitorOn && wbWe) begin
			if (wGrp.size() == 0) begin
				$display("Unexpected write-back of %h to r%0d", wbData, wbReg);
				errorCount++;
			end else begin
				curGroup = wGrp.pop_front();
				checkValue("wbReg", 32'(wbReg), wReg.pop_front());
				checkValue("wbData", wbData, wVal.pop_front());
				reportGroup(curGroup);
			end
		end
		if (monitorOn && dmWe) begin
			if (sGrp.size() == 0) begin
				$display("Unexpected store of %h to %h", dmWData, dmAddr);
				errorCount++;
			end else begin
				curGroup = sGrp.pop_front();
				checkValue("dmAddr", dmAddr, sAddr.pop_front());
				checkValue("dmWData", dmWData, sData.pop_front());
				checkValue("dmByteEn", 32'(dmByteEn), sBe.pop_front());
				reportGroup(curGroup);
			end
		end
	end

	initial begin
		arstN = 1'b0;
		for (int i = 0; i < 1024; i++)
			dmem[i] <= '0;
		for (int i = 0; i < 4; i++)
			groupErr[i] = 0;
		readProgram();
		limit = 8 * numWords + 100;

		// Group 0 keeps the outputs quiet through reset and the first cycles
		curGroup = 0;
		repeat (16) begin
			@(negedge clk);
			checkValue("dmWe", 32'(dmWe), 32'h0);
			checkValue("wbWe", 32'(wbWe), 32'h0);
		end
		@(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkValue("pcFetch", pcFetch, corePkg::ResetPc);
		checkValue("dmWe", 32'(dmWe), 32'h0);
		checkValue("wbWe", 32'(wbWe), 32'h0);
		repeat (2) begin
			@(negedge clk);
			checkValue("dmWe", 32'(dmWe), 32'h0);
			checkValue("wbWe", 32'(wbWe), 32'h0);
		end
		$display("Group 0 (%s) done, %0d errors", groupName(0), groupErr[0]);
		monitorOn = 1'b1;

		while ((wGrp.size() > 0 || sGrp.size() > 0) && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, %0d write-backs and %0d stores never seen",
				cycles, wGrp.size(), sGrp.size());
			errorCount++;
		end else begin
			// Idle time to catch stray events
			repeat (20) @(negedge clk);
		end

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== bench/programInput.txt ====
# I word | D addr data | W group reg(dec) value | S group addr data byteEn
# Program starts at 0x3000, unused words fetch as nop
I 3C018000
I 34210005
I 24020007
I 2403FFFD
I 0062202A
I 0041282A
I 00433023
I 00263826
I 00E34024
I 00084900
I 000857C2
I 306BF0F0
I 012A6025
I 018C6021
I 240D0100
I 81AE0000
I 01CE7821
I 91B00000
I 91B10003
I 8DB20000
I ADA20004
I A1A30005
I 8DB30004
I A1B30003
I 8DB40000
I 10430002
I 24150001
I 26B50002
I 16A00002
I 24160022
I 24160099
I 12D60002
I 24170033
I 24170044
I 0C000C28
I 24180055
I 24190066
I 08000C2C
I 241A0077
I 241A00EE
I 241B0088
I 03E00008
I 241C0099
I 241C00AA
I 03FBE825
D 00000100 12345680
W 1 1 80000000
W 1 1 80000005
W 1 2 00000007
W 1 3 FFFFFFFD
W 1 4 00000001
W 1 5 00000000
W 1 6 0000000A
W 1 7 8000000F
W 1 8 8000000D
W 1 9 000000D0
W 1 10 00000001
W 1 11 0000F0F0
W 1 12 000000D1
W 1 12 000001A2
W 2 13 00000100
W 2 14 FFFFFF80
W 2 15 FFFFFF00
W 2 16 00000080
W 2 17 00000012
W 2 18 12345680
W 2 19 0000FD07
W 2 20 07345680
S 2 00000104 00000007 F
S 2 00000104 FDFDFDFD 2
S 2 00000100 07070707 8
W 3 21 00000001
W 3 21 00000003
W 3 22 00000022
W 3 23 00000033
W 3 31 00003090
W 3 24 00000055
W 3 27 00000088
W 3 28 00000099
W 3 25 00000066
W 3 26 00000077
W 3 29 00003098

// ==== hdl/aluUnit.sv ====
`timescale 1ns/10ps

module aluUnit (
	input corePkg::word_t srcA,
	input corePkg::word_t srcB,
	input logic [4:0] shamt,
	input corePkg::aluOp_t aluOp,
	output corePkg::word_t result
);

	always_comb begin
		case (aluOp)
			corePkg::AluAdd: result = srcA + srcB;
			corePkg::AluSub: result = srcA - srcB;
			corePkg::AluAnd: result = srcA & srcB;
			corePkg::AluOr: result = srcA | srcB;
			corePkg::AluXor: result = srcA ^ srcB;
			// Signed compare
			corePkg::AluSlt: result = {31'h0, $signed(srcA) < $signed(srcB)};
			corePkg::AluSll: result = srcB << shamt;
			corePkg::AluSrl: result = srcB >> shamt;
			// Immediate arrives already in the upper half
			corePkg::AluLui: result = srcB;
			default: result = '0;
		endcase
	end

endmodule

// ==== hdl/corePkg.sv ====
package corePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [3:0] aluOp_t;
	typedef logic [1:0] fwdSel_t;
	typedef logic [1:0] extMode_t;
	typedef logic [1:0] a3Sel_t;
	typedef logic [3:0] byteEn_t;

	typedef enum logic [2:0] {
		ClsAlu,
		ClsBranch,
		ClsJr,
		ClsJump,
		ClsLoad,
		ClsStore,
		ClsNop
	} instrClass_t;

	// Primary opcodes
	localparam logic [5:0] OpSpecial = 6'h00;
	localparam logic [5:0] OpJ = 6'h02;
	localparam logic [5:0] OpJal = 6'h03;
	localparam logic [5:0] OpBeq = 6'h04;
	localparam logic [5:0] OpBne = 6'h05;
	localparam logic [5:0] OpAddiu = 6'h09;
	localparam logic [5:0] OpAndi = 6'h0c;
	localparam logic [5:0] OpOri = 6'h0d;
	localparam logic [5:0] OpLui = 6'h0f;
	localparam logic [5:0] OpLb = 6'h20;
	localparam logic [5:0] OpLw = 6'h23;
	localparam logic [5:0] OpLbu = 6'h24;
	localparam logic [5:0] OpSb = 6'h28;
	localparam logic [5:0] OpSw = 6'h2b;

	// Function field of special
	localparam logic [5:0] FnSll = 6'h00;
	localparam logic [5:0] FnSrl = 6'h02;
	localparam logic [5:0] FnJr = 6'h08;
	localparam logic [5:0] FnAddu = 6'h21;
	localparam logic [5:0] FnSubu = 6'h23;
	localparam logic [5:0] FnAnd = 6'h24;
	localparam logic [5:0] FnOr = 6'h25;
	localparam logic [5:0] FnXor = 6'h26;
	localparam logic [5:0] FnSlt = 6'h2a;

	localparam aluOp_t AluAdd = 4'd0;
	localparam aluOp_t AluSub = 4'd1;
	localparam aluOp_t AluAnd = 4'd2;
	localparam aluOp_t AluOr = 4'd3;
	localparam aluOp_t AluXor = 4'd4;
	localparam aluOp_t AluSlt = 4'd5;
	localparam aluOp_t AluSll = 4'd6;
	localparam aluOp_t AluSrl = 4'd7;
	localparam aluOp_t AluLui = 4'd8;

	localparam fwdSel_t FwdNone = 2'd0;
	localparam fwdSel_t FwdEm = 2'd1;
	localparam fwdSel_t FwdMw = 2'd2;

	localparam extMode_t ExtZero = 2'd0;
	localparam extMode_t ExtSign = 2'd1;
	localparam extMode_t ExtUpper = 2'd2;

	localparam a3Sel_t A3Rd = 2'd0;
	localparam a3Sel_t A3Rt = 2'd1;
	localparam a3Sel_t A3Ra = 2'd2;

	localparam word_t ResetPc = 32'h0000_3000;

endpackage

// ==== hdl/coreTop.sv ====
`timescale 1ns/10ps

module coreTop (
	input logic clk,
	input logic arstN,
	output corePkg::word_t pcFetch,
	input corePkg::word_t fetchInstr,
	output corePkg::word_t dmAddr,
	output corePkg::word_t dmWData,
	output corePkg::byteEn_t dmByteEn,
	output logic dmWe,
	input corePkg::word_t dmRData,
	output logic wbWe,
	output corePkg::regAddr_t wbReg,
	output corePkg::word_t wbData
);

	// Decoder fields
	corePkg::word_t instrD;
	logic regWe;
	corePkg::a3Sel_t a3Sel;
	corePkg::extMode_t extMode;
	logic immToB;
	corePkg::aluOp_t aluOp;
	logic isLoad;
	logic isStore;
	logic loadSigned;
	logic byteAccess;
	logic [1:0] branchOp;
	logic jump;
	logic jumpReg;
	logic link;
	logic useRs;
	logic useRt;

	// Hazard detection
	corePkg::regAddr_t rsD;
	corePkg::regAddr_t rtD;
	corePkg::regAddr_t rsE;
	corePkg::regAddr_t rtE;
	corePkg::regAddr_t a3E;
	corePkg::regAddr_t a3M;
	corePkg::regAddr_t a3W;
	logic regWeE;
	logic regWeM;
	logic regWeW;
	logic loadE;
	logic loadM;
	logic stall;
	corePkg::fwdSel_t fwdD1;
	corePkg::fwdSel_t fwdD2;
	corePkg::fwdSel_t fwdE1;
	corePkg::fwdSel_t fwdE2;

	// Decode needs its operands now for a compare or jr
	wire branchOrJr = (branchOp != 2'b00) || jumpReg;

	datapath dp (.*);

	instrDecode dec (
		.instr(instrD),
		.*
	);

	hazardUnit hzd (.*);

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/10ps

module datapath (
	input logic clk,
	input logic arstN,
	// Decoder
	output corePkg::word_t instrD,
	input logic regWe,
	input corePkg::a3Sel_t a3Sel,
	input corePkg::extMode_t extMode,
	input logic immToB,
	input corePkg::aluOp_t aluOp,
	input logic isLoad,
	input logic isStore,
	input logic loadSigned,
	input logic byteAccess,
	input logic [1:0] branchOp,
	input logic jump,
	input logic jumpReg,
	input logic link,
	// Hazard unit
	output corePkg::regAddr_t rsD,
	output corePkg::regAddr_t rtD,
	output corePkg::regAddr_t rsE,
	output corePkg::regAddr_t rtE,
	output corePkg::regAddr_t a3E,
	output corePkg::regAddr_t a3M,
	output corePkg::regAddr_t a3W,
	output logic regWeE,
	output logic regWeM,
	output logic regWeW,
	output logic loadE,
	output logic loadM,
	input logic stall,
	input corePkg::fwdSel_t fwdD1,
	input corePkg::fwdSel_t fwdD2,
	input corePkg::fwdSel_t fwdE1,
	input corePkg::fwdSel_t fwdE2,
	// Instruction and data memory
	output corePkg::word_t pcFetch,
	input corePkg::word_t fetchInstr,
	output corePkg::word_t dmAddr,
	output corePkg::word_t dmWData,
	output corePkg::byteEn_t dmByteEn,
	output logic dmWe,
	input corePkg::word_t dmRData,
	// Write-back observation
	output logic wbWe,
	output corePkg::regAddr_t wbReg,
	output corePkg::word_t wbData
);

	corePkg::word_t pcPlus4F;
	corePkg::word_t pcPlus4D;
	corePkg::word_t nextPc;
	corePkg::word_t rfRd1;
	corePkg::word_t rfRd2;
	corePkg::word_t rsValD;
	corePkg::word_t rtValD;
	corePkg::word_t immD;
	corePkg::regAddr_t a3D;
	logic takenD;

	corePkg::word_t rsValE;
	corePkg::word_t rtValE;
	corePkg::word_t immE;
	corePkg::word_t pcPlus8E;
	logic [4:0] shamtE;
	corePkg::aluOp_t aluOpE;
	logic immToBE;
	logic linkE;
	logic loadSignedE;
	logic byteAccessE;
	logic isStoreE;
	corePkg::word_t srcAE;
	corePkg::word_t rtFwdE;
	corePkg::word_t aluResultE;
	corePkg::word_t resultE;

	corePkg::word_t resultM;
	corePkg::word_t storeDataM;
	logic isStoreM;
	logic loadSignedM;
	logic byteAccessM;

	corePkg::word_t resultW;
	corePkg::word_t memWordW;
	corePkg::word_t loadDataW;
	logic loadSignedW;
	logic byteAccessW;
	logic loadW;

	function automatic corePkg::word_t fwdMux(corePkg::fwdSel_t sel, corePkg::word_t own,
			corePkg::word_t memVal, corePkg::word_t wbVal);
		case (sel)
			corePkg::FwdEm: return memVal;
			corePkg::FwdMw: return wbVal;
			default: return own;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Fetch

	assign pcPlus4F = pcFetch + 32'd4;

	// Decode redirects fetch after the delay slot
	always_comb begin
		if (jumpReg)
			nextPc = rsValD;
		else if (jump)
			nextPc = {pcPlus4D[31:28], instrD[25:0], 2'b00};
		else if (takenD)
			nextPc = pcPlus4D + {immD[29:0], 2'b00};
		else
			nextPc = pcPlus4F;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcFetch <= corePkg::ResetPc;
			instrD <= '0;
		end else if (!stall) begin
			pcFetch <= nextPc;
			instrD <= fetchInstr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall)
			pcPlus4D <= pcPlus4F;
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode

	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];

	regFile rf (
		.clk(clk),
		.arstN(arstN),
		.we(wbWe),
		.ra1(rsD),
		.ra2(rtD),
		.wa(a3W),
		.wd(wbData),
		.rd1(rfRd1),
		.rd2(rfRd2)
	);

	assign rsValD = fwdMux(fwdD1, rfRd1, resultM, wbData);
	assign rtValD = fwdMux(fwdD2, rfRd2, resultM, wbData);
	assign takenD = (branchOp[0] && rsValD == rtValD) || (branchOp[1] && rsValD != rtValD);

	always_comb begin
		case (extMode)
			corePkg::ExtZero: immD = {16'h0, instrD[15:0]};
			corePkg::ExtUpper: immD = {instrD[15:0], 16'h0};
			default: immD = {{16{instrD[15]}}, instrD[15:0]};
		endcase
		case (a3Sel)
			corePkg::A3Rt: a3D = rtD;
			corePkg::A3Ra: a3D = 5'd31;
			default: a3D = instrD[15:11];
		endcase
	end

	// A stall turns the decode instruction into a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWeE <= 1'b0;
			loadE <= 1'b0;
			isStoreE <= 1'b0;
		end else begin
			regWeE <= regWe && !stall;
			loadE <= isLoad && !stall;
			isStoreE <= isStore && !stall;
		end
	end

	always_ff @(posedge clk) begin
		rsValE <= rsValD;
		rtValE <= rtValD;
		immE <= immD;
		pcPlus8E <= pcPlus4D + 32'd4;
		shamtE <= instrD[10:6];
		aluOpE <= aluOp;
		immToBE <= immToB;
		linkE <= link;
		loadSignedE <= loadSigned;
		byteAccessE <= byteAccess;
		rsE <= rsD;
		rtE <= rtD;
		a3E <= a3D;
	end

	////////////////////////////////////////////////////////////////////////////
	// Execute

	assign srcAE = fwdMux(fwdE1, rsValE, resultM, wbData);
	assign rtFwdE = fwdMux(fwdE2, rtValE, resultM, wbData);

	aluUnit alu (
		.srcA(srcAE),
		.srcB(immToBE ? immE : rtFwdE),
		.shamt(shamtE),
		.aluOp(aluOpE),
		.result(aluResultE)
	);

	// jal writes its return address
	assign resultE = linkE ? pcPlus8E : aluResultE;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWeM <= 1'b0;
			loadM <= 1'b0;
			isStoreM <= 1'b0;
		end else begin
			regWeM <= regWeE;
			loadM <= loadE;
			isStoreM <= isStoreE;
		end
	end

	always_ff @(posedge clk) begin
		resultM <= resultE;
		storeDataM <= rtFwdE;
		loadSignedM <= loadSignedE;
		byteAccessM <= byteAccessE;
		a3M <= a3E;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory and write-back

	memAlign storeAlign (
		.storeData(storeDataM),
		.addr(resultM),
		.loadWord(dmRData),
		.byteAccess(byteAccessM),
		.loadSigned(loadSignedM),
		.isStore(isStoreM),
		.wData(dmWData),
		.loadData(),
		.byteEn(dmByteEn)
	);

	assign dmAddr = {resultM[31:2], 2'b00};
	assign dmWe = isStoreM;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWeW <= 1'b0;
			loadW <= 1'b0;
		end else begin
			regWeW <= regWeM;
			loadW <= loadM;
		end
	end

	always_ff @(posedge clk) begin
		resultW <= resultM;
		memWordW <= dmRData;
		loadSignedW <= loadSignedM;
		byteAccessW <= byteAccessM;
		a3W <= a3M;
	end

	memAlign loadAlign (
		.storeData('0),
		.addr(resultW),
		.loadWord(memWordW),
		.byteAccess(byteAccessW),
		.loadSigned(loadSignedW),
		.isStore(1'b0),
		.wData(),
		.loadData(loadDataW),
		.byteEn()
	);

	assign wbData = loadW ? loadDataW : resultW;
	assign wbWe = regWeW && (a3W != '0);
	assign wbReg = a3W;

	assert property (@(posedge clk) disable iff (!arstN) pcFetch[1:0] == 2'b00)
		else $error("datapath: fetch address %h not word aligned", pcFetch);

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
	input corePkg::regAddr_t rsD,
	input corePkg::regAddr_t rtD,
	input corePkg::regAddr_t rsE,
	input corePkg::regAddr_t rtE,
	input corePkg::regAddr_t a3E,
	input corePkg::regAddr_t a3M,
	input corePkg::regAddr_t a3W,
	input logic useRs,
	input logic useRt,
	input logic branchOrJr,
	input logic regWeE,
	input logic regWeM,
	input logic regWeW,
	input logic loadE,
	input logic loadM,
	output logic stall,
	output corePkg::fwdSel_t fwdD1,
	output corePkg::fwdSel_t fwdD2,
	output corePkg::fwdSel_t fwdE1,
	output corePkg::fwdSel_t fwdE2
);

	logic hitE;
	logic hitM;

	// Younger producer wins and a load in memory has no data yet
	function automatic corePkg::fwdSel_t pickFwd(corePkg::regAddr_t src);
		if (src == '0)
			return corePkg::FwdNone;
		else if (regWeM && !loadM && a3M == src)
			return corePkg::FwdEm;
		else if (regWeW && a3W == src)
			return corePkg::FwdMw;
		else
			return corePkg::FwdNone;
	endfunction

	always_comb begin
		fwdD1 = pickFwd(rsD);
		fwdD2 = pickFwd(rtD);
		fwdE1 = pickFwd(rsE);
		fwdE2 = pickFwd(rtE);
	end

	// Decode reads a register still being produced further down
	assign hitE = regWeE && (a3E != '0) && ((useRs && a3E == rsD) || (useRt && a3E == rtD));
	assign hitM = regWeM && (a3M != '0) && ((useRs && a3M == rsD) || (useRt && a3M == rtD));

	assign stall = (hitE && (loadE || branchOrJr)) || (hitM && loadM && branchOrJr);

	// A branch that goes ahead takes a memory-stage producer through the forward
	always_comb begin
		if (branchOrJr && !stall && regWeM && a3M != '0) begin
			if (useRs && a3M == rsD)
				assert (fwdD1 == corePkg::FwdEm)
					else $error("hazardUnit: branch misses rs from memory stage");
			if (useRt && a3M == rtD)
				assert (fwdD2 == corePkg::FwdEm)
					else $error("hazardUnit: branch misses rt from memory stage");
		end
	end

endmodule

// ==== hdl/instrDecode.sv ====
`timescale 1ns/10ps

module instrDecode (
	input corePkg::word_t instr,
	output logic regWe,
	output corePkg::a3Sel_t a3Sel,
	output corePkg::extMode_t extMode,
	output logic immToB,
	output corePkg::aluOp_t aluOp,
	output logic isLoad,
	output logic isStore,
	output logic loadSigned,
	output logic byteAccess,
	output logic [1:0] branchOp,
	output logic jump,
	output logic jumpReg,
	output logic link,
	output logic useRs,
	output logic useRt
);

	logic [5:0] opcode;
	logic [5:0] funct;
	corePkg::instrClass_t instrClass;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		case (opcode)
			corePkg::OpSpecial: begin
				case (funct)
					corePkg::FnAddu, corePkg::FnSubu, corePkg::FnAnd, corePkg::FnOr,
					corePkg::FnXor, corePkg::FnSlt, corePkg::FnSll, corePkg::FnSrl:
						instrClass = corePkg::ClsAlu;
					corePkg::FnJr:
						instrClass = corePkg::ClsJr;
					default:
						instrClass = corePkg::ClsNop;
				endcase
			end
			corePkg::OpAddiu, corePkg::OpAndi, corePkg::OpOri, corePkg::OpLui:
				instrClass = corePkg::ClsAlu;
			corePkg::OpBeq, corePkg::OpBne:
				instrClass = corePkg::ClsBranch;
			corePkg::OpJ, corePkg::OpJal:
				instrClass = corePkg::ClsJump;
			corePkg::OpLw, corePkg::OpLb, corePkg::OpLbu:
				instrClass = corePkg::ClsLoad;
			corePkg::OpSw, corePkg::OpSb:
				instrClass = corePkg::ClsStore;
			default:
				instrClass = corePkg::ClsNop;
		endcase
	end

	// Control fields per class, defaults describe a nop
	always_comb begin
		regWe = 1'b0;
		a3Sel = corePkg::A3Rd;
		extMode = corePkg::ExtSign;
		immToB = 1'b0;
		aluOp = corePkg::AluAdd;
		isLoad = 1'b0;
		isStore = 1'b0;
		loadSigned = 1'b0;
		byteAccess = 1'b0;
		branchOp = 2'b00;
		jump = 1'b0;
		jumpReg = 1'b0;
		link = 1'b0;
		useRs = 1'b0;
		useRt = 1'b0;
		case (instrClass)
			corePkg::ClsAlu: begin
				regWe = 1'b1;
				if (opcode == corePkg::OpSpecial) begin
					// Shifts take rt and shamt only
					useRs = (funct != corePkg::FnSll) && (funct != corePkg::FnSrl);
					useRt = 1'b1;
					case (funct)
						corePkg::FnSubu: aluOp = corePkg::AluSub;
						corePkg::FnAnd: aluOp = corePkg::AluAnd;
						corePkg::FnOr: aluOp = corePkg::AluOr;
						corePkg::FnXor: aluOp = corePkg::AluXor;
						corePkg::FnSlt: aluOp = corePkg::AluSlt;
						corePkg::FnSll: aluOp = corePkg::AluSll;
						corePkg::FnSrl: aluOp = corePkg::AluSrl;
						default: aluOp = corePkg::AluAdd;
					endcase
				end else begin
					a3Sel = corePkg::A3Rt;
					immToB = 1'b1;
					useRs = (opcode != corePkg::OpLui);
					case (opcode)
						corePkg::OpAndi: begin
							aluOp = corePkg::AluAnd;
							extMode = corePkg::ExtZero;
						end
						corePkg::OpOri: begin
							aluOp = corePkg::AluOr;
							extMode = corePkg::ExtZero;
						end
						corePkg::OpLui: begin
							aluOp = corePkg::AluLui;
							extMode = corePkg::ExtUpper;
						end
						default: aluOp = corePkg::AluAdd;
					endcase
				end
			end
			corePkg::ClsBranch: begin
				branchOp = {opcode == corePkg::OpBne, opcode == corePkg::OpBeq};
				useRs = 1'b1;
				useRt = 1'b1;
			end
			corePkg::ClsJr: begin
				jumpReg = 1'b1;
				useRs = 1'b1;
			end
			corePkg::ClsJump: begin
				jump = 1'b1;
				if (opcode == corePkg::OpJal) begin
					link = 1'b1;
					regWe = 1'b1;
					a3Sel = corePkg::A3Ra;
				end
			end
			corePkg::ClsLoad: begin
				regWe = 1'b1;
				a3Sel = corePkg::A3Rt;
				immToB = 1'b1;
				isLoad = 1'b1;
				loadSigned = (opcode == corePkg::OpLb);
				byteAccess = (opcode != corePkg::OpLw);
				useRs = 1'b1;
			end
			corePkg::ClsStore: begin
				immToB = 1'b1;
				isStore = 1'b1;
				byteAccess = (opcode == corePkg::OpSb);
				useRs = 1'b1;
				useRt = 1'b1;
			end
			default: ;
		endcase
	end

	always_comb begin
		assert (!(isLoad && isStore))
			else $error("instrDecode: load and store both set for %h", instr);
	end

endmodule

// ==== hdl/memAlign.sv ====
`timescale 1ns/10ps

module memAlign (
	input corePkg::word_t storeData,
	input corePkg::word_t addr,
	input corePkg::word_t loadWord,
	input logic byteAccess,
	input logic loadSigned,
	input logic isStore,
	output corePkg::word_t wData,
	output corePkg::word_t loadData,
	output corePkg::byteEn_t byteEn
);

	logic [1:0] lane;
	logic [7:0] loadByte;

	assign lane = addr[1:0];

	// Store side, sb copies the byte to every lane
	assign wData = byteAccess ? {4{storeData[7:0]}} : storeData;

	always_comb begin
		if (!isStore)
			byteEn = 4'b0000;
		else if (byteAccess)
			byteEn = 4'b0001 << lane;
		else
			byteEn = 4'b1111;
	end

	// Load side
	assign loadByte = loadWord[8*lane +: 8];

	always_comb begin
		if (!byteAccess)
			loadData = loadWord;
		else if (loadSigned)
			loadData = {{24{loadByte[7]}}, loadByte};
		else
			loadData = {24'h0, loadByte};
	end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic arstN,
	input logic we,
	input corePkg::regAddr_t ra1,
	input corePkg::regAddr_t ra2,
	input corePkg::regAddr_t wa,
	input corePkg::word_t wd,
	output corePkg::word_t rd1,
	output corePkg::word_t rd2
);

	corePkg::word_t regs [1:31];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// Write in the same cycle bypasses to the reads
	always_comb begin
		if (ra1 == '0)
			rd1 = '0;
		else if (we && wa == ra1)
			rd1 = wd;
		else
			rd1 = regs[ra1];
		if (ra2 == '0)
			rd2 = '0;
		else if (we && wa == ra2)
			rd2 = wd;
		else
			rd2 = regs[ra2];
	end

	assert property (@(posedge clk) disable iff (!arstN) (ra1 == '0) |-> (rd1 == '0))
		else $error("regFile: register 0 read as %h", rd1);

endmodule

// ==== verilog.f ====
hdl/corePkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/memAlign.sv
hdl/instrDecode.sv
hdl/hazardUnit.sv
hdl/datapath.sv
hdl/coreTop.sv
bench/coreBench.sv
